/* Makefile */
# Verilator flow for the execute stage

VERILATOR  ?= verilator
TOP        ?= exec_stage_tb
RTL_TOP    ?= exec_stage
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
RTL_SRCS   ?= design/exec_pkg.sv design/exec_alu.sv design/branch_resolve.sv \
              design/mul_pipe.sv design/exec_ctrl.sv design/exec_stage.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -Idesign $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TEST OK" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/branch_resolve.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module branch_resolve (
  input  logic [`EXEC_XLEN-1:0] pc,
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  input  logic [`EXEC_XLEN-1:0] imm,
  input  exec_pkg::exec_op_u    op,
  input  logic                  prediction,
  output exec_pkg::br_res_t     br_res
);

  logic cond_true;

  // compare operands per condition code
  always_comb begin
    case (op.br.cond)
      exec_pkg::BR_EQ:  cond_true = a == b;
      exec_pkg::BR_NE:  cond_true = a != b;
      exec_pkg::BR_LT:  cond_true = $signed(a) < $signed(b);
      exec_pkg::BR_GE:  cond_true = $signed(a) >= $signed(b);
      exec_pkg::BR_LTU: cond_true = a < b;
      exec_pkg::BR_GEU: cond_true = a >= b;
      // reserved codes never taken
      default:          cond_true = 1'b0;
    endcase
  end

  // jumps are always taken
  assign br_res.taken = op.br.jump | cond_true;

  // pc relative target for branch and jump alike
  assign br_res.target = pc + imm;

  // return address and fall-through
  assign br_res.link = pc + `EXEC_INSN_BYTES;

  // a jump always redirects
  // a branch only when the outcome disagrees
  assign br_res.mispredict = op.br.jump | (br_res.taken != prediction);

endmodule

/* design/exec_alu.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_alu (
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  input  exec_pkg::exec_op_u    op,
  output logic [`EXEC_XLEN-1:0] result
);

  logic [4:0] shamt;

  // only low five bits shift
  assign shamt = b[4:0];

  always_comb begin
    case (op.alu)
      exec_pkg::ALU_ADD: begin
        result = a + b;
      end
      exec_pkg::ALU_SUB: begin
        result = a - b;
      end
      exec_pkg::ALU_AND: begin
        result = a & b;
      end
      exec_pkg::ALU_OR: begin
        result = a | b;
      end
      exec_pkg::ALU_XOR: begin
        result = a ^ b;
      end
      exec_pkg::ALU_SLL: begin
        result = a << shamt;
      end
      exec_pkg::ALU_SRL: begin
        result = a >> shamt;
      end
      exec_pkg::ALU_SRA: begin
        // sign fill from bit 31
        result = $signed(a) >>> shamt;
      end
      exec_pkg::ALU_SLT: begin
        result = {{(`EXEC_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      end
      exec_pkg::ALU_SLTU: begin
        result = {{(`EXEC_XLEN-1){1'b0}}, a < b};
      end
      default: begin
        // unused encodings read as zero
        result = '0;
      end
    endcase
  end

endmodule

/* design/exec_ctrl.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_ctrl (
  input  logic                  CLK,
  input  logic                  nRST,
  input  exec_pkg::issue_t      issue,
  output logic                  issue_ready,
  input  logic                  flush,
  input  logic                  commit_stall,
  input  logic [`EXEC_XLEN-1:0] alu_result,
  input  exec_pkg::br_res_t     br_res,
  input  exec_pkg::mul_res_t    mul_res,
  output logic                  mul_start,
  output exec_pkg::wb_t         wb,
  output exec_pkg::commit_t     commit,
  output exec_pkg::redirect_t   redirect
);

  logic                   is_mul;
  logic                   is_branch_unit;
  logic                   is_jump;
  logic                   br_taken;
  logic                   accept;
  logic                   single_cycle;
  logic [`EXEC_XLEN-1:0]  resolved_addr;
  logic                   sc_valid;
  logic                   sc_wen;
  logic [`EXEC_TAG_W-1:0] sc_tag;
  logic [`EXEC_REG_W-1:0] sc_rd;
  logic [`EXEC_XLEN-1:0]  sc_data;

  assign is_mul         = issue.unit == exec_pkg::UNIT_MUL;
  assign is_branch_unit = issue.unit == exec_pkg::UNIT_BRANCH;
  assign is_jump        = is_branch_unit & issue.op.br.jump;
  // alu ops never count as taken
  assign br_taken       = is_branch_unit & br_res.taken;

  // mul in stage two owns the next wb slot
  // a new mul lands later and may still go
  assign issue_ready  = ~commit_stall & ~flush & ~(mul_res.busy_next & ~is_mul);
  assign accept       = issue.valid & issue_ready;
  assign single_cycle = accept & ~is_mul;
  assign mul_start    = accept & is_mul;

  // target when taken, else fall through
  assign resolved_addr = br_taken ? br_res.target : br_res.link;

  // single cycle completion, control bits
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      sc_valid <= 1'b0;
      sc_wen   <= 1'b0;
    end else begin
      sc_valid <= single_cycle;
      // branches only retire their tag
      sc_wen   <= single_cycle & (~is_branch_unit | is_jump);
    end
  end

  // single cycle completion, payload
  always_ff @(posedge CLK) begin
    sc_tag  <= issue.tag;
    sc_rd   <= issue.rd;
    // jumps write the link value
    sc_data <= is_jump ? br_res.link : alu_result;
  end

  // mul has priority, issue gating keeps the two apart
  always_comb begin
    if (mul_res.wb.valid) begin
      wb = mul_res.wb;
    end else begin
      wb.valid = sc_valid;
      wb.tag   = sc_tag;
      wb.rd    = sc_rd;
      wb.wen   = sc_wen;
      wb.data  = sc_data;
    end
  end

  // execute to commit record
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      commit <= '0;
    end else if (flush) begin
      commit <= '0;
    end else if (!commit_stall) begin
      // mul ops bypass the record
      commit.valid         <= single_cycle;
      commit.pc            <= issue.pc;
      commit.pc4           <= br_res.link;
      commit.branch_instr  <= is_branch_unit & ~issue.op.br.jump;
      commit.taken         <= br_taken;
      commit.prediction    <= issue.prediction;
      commit.resolved_addr <= resolved_addr;
    end
  end

  // one cycle redirect pulse toward fetch
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      redirect <= '0;
    end else if (flush) begin
      redirect <= '0;
    end else begin
      redirect.valid <= single_cycle & is_branch_unit & br_res.mispredict;
      redirect.addr  <= resolved_addr;
    end
  end

endmodule

/* design/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// data word width
`define EXEC_XLEN 32

// completion buffer index, 8 entries
`define EXEC_TAG_W 3

// architectural register number
`define EXEC_REG_W 5

// multiplier latency in cycles
// fixed, the pipe is built around three stages
`define EXEC_MUL_STAGES 3

// pc step for link and fall-through
`define EXEC_INSN_BYTES 4

`endif

/* design/exec_pkg.sv */
`include "exec_params.svh"

package exec_pkg;

  // functional unit selected at issue
  typedef enum logic [1:0] {
    UNIT_ALU    = 2'd0,
    UNIT_BRANCH = 2'd1,
    UNIT_MUL    = 2'd2
  } unit_e;

  // integer alu operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // branch compare kinds
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd2,
    BR_GE  = 3'd3,
    BR_LTU = 3'd4,
    BR_GEU = 3'd5
  } br_cond_e;

  typedef struct packed {
    br_cond_e cond;
    // unconditional, always redirects
    logic     jump;
  } br_view_t;

  // multiply result selection and operand signedness
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_H   = 2'd1,
    MUL_HU  = 2'd2,
    MUL_HSU = 2'd3
  } mul_op_e;

  typedef struct packed {
    mul_op_e    func;
    logic [1:0] pad;
  } mul_view_t;

  // one op field, meaning depends on unit
  typedef union packed {
    alu_op_e   alu;
    br_view_t  br;
    mul_view_t mul;
  } exec_op_u;

  typedef struct packed {
    logic                   valid;
    unit_e                  unit;
    exec_op_u               op;
    logic [`EXEC_TAG_W-1:0] tag;
    logic [`EXEC_REG_W-1:0] rd;
    logic [`EXEC_XLEN-1:0]  pc;
    logic [`EXEC_XLEN-1:0]  a;
    logic [`EXEC_XLEN-1:0]  b;
    logic [`EXEC_XLEN-1:0]  imm;
    logic                   prediction;
  } issue_t;

  // completion buffer writeback
  typedef struct packed {
    logic                   valid;
    logic [`EXEC_TAG_W-1:0] tag;
    logic [`EXEC_REG_W-1:0] rd;
    logic                   wen;
    logic [`EXEC_XLEN-1:0]  data;
  } wb_t;

  typedef struct packed {
    logic                  valid;
    logic [`EXEC_XLEN-1:0] pc;
    logic [`EXEC_XLEN-1:0] pc4;
    logic                  branch_instr;
    logic                  taken;
    logic                  prediction;
    logic [`EXEC_XLEN-1:0] resolved_addr;
  } commit_t;

  typedef struct packed {
    logic                  valid;
    logic [`EXEC_XLEN-1:0] addr;
  } redirect_t;

  typedef struct packed {
    logic                  taken;
    logic [`EXEC_XLEN-1:0] target;
    logic [`EXEC_XLEN-1:0] link;
    logic                  mispredict;
  } br_res_t;

  typedef struct packed {
    wb_t  wb;
    // result leaves the pipe next cycle
    logic busy_next;
  } mul_res_t;

endpackage

/* design/exec_stage.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  exec_pkg::issue_t    issue,
  output logic                issue_ready,
  input  logic                flush,
  input  logic                commit_stall,
  output exec_pkg::wb_t       wb,
  output exec_pkg::commit_t   commit,
  output exec_pkg::redirect_t redirect
);

  logic [`EXEC_XLEN-1:0] alu_result;
  exec_pkg::br_res_t     br_res;
  exec_pkg::mul_res_t    mul_res;
  logic                  mul_start;

  // issue acceptance, wb arbitration, commit and redirect
  exec_ctrl u_ctrl (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue        (issue),
    .issue_ready  (issue_ready),
    .flush        (flush),
    .commit_stall (commit_stall),
    .alu_result   (alu_result),
    .br_res       (br_res),
    .mul_res      (mul_res),
    .mul_start    (mul_start),
    .wb           (wb),
    .commit       (commit),
    .redirect     (redirect)
  );

  // combinational units see the raw issue fields
  exec_alu u_alu (
    .a      (issue.a),
    .b      (issue.b),
    .op     (issue.op),
    .result (alu_result)
  );

  branch_resolve u_branch (
    .pc         (issue.pc),
    .a          (issue.a),
    .b          (issue.b),
    .imm        (issue.imm),
    .op         (issue.op),
    .prediction (issue.prediction),
    .br_res     (br_res)
  );

  mul_pipe u_mul (
    .CLK     (CLK),
    .nRST    (nRST),
    .start   (mul_start),
    .issue   (issue),
    .mul_res (mul_res)
  );

endmodule

/* design/mul_pipe.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module mul_pipe (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               start,
  input  exec_pkg::issue_t   issue,
  output exec_pkg::mul_res_t mul_res
);

  // per stage bookkeeping, index 0 is stage one
  logic [`EXEC_MUL_STAGES-1:0]                  vld;
  logic [`EXEC_MUL_STAGES-1:0][`EXEC_TAG_W-1:0] tag_q;
  logic [`EXEC_MUL_STAGES-1:0][`EXEC_REG_W-1:0] rd_q;
  exec_pkg::mul_op_e                            op1_q;
  exec_pkg::mul_op_e                            op2_q;
  logic                                         a_signed;
  logic                                         b_signed;
  logic signed [`EXEC_XLEN:0]                   a_q;
  logic signed [`EXEC_XLEN:0]                   b_q;
  logic signed [2*`EXEC_XLEN+1:0]               prod_full;
  logic [2*`EXEC_XLEN-1:0]                      prod_q;
  logic [`EXEC_XLEN-1:0]                        data_q;

  // operand signedness from the mul view
  always_comb begin
    case (issue.op.mul.func)
      exec_pkg::MUL_H: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      exec_pkg::MUL_HSU: begin
        a_signed = 1'b1;
        b_signed = 1'b0;
      end
      // low half same either way
      default: begin
        a_signed = 1'b0;
        b_signed = 1'b0;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      vld <= '0;
    end else begin
      vld <= {vld[`EXEC_MUL_STAGES-2:0], start};
    end
  end

  // 33 bit extension covers all four kinds with one signed multiply
  assign prod_full = a_q * b_q;

  always_ff @(posedge CLK) begin
    tag_q  <= {tag_q[`EXEC_MUL_STAGES-2:0], issue.tag};
    rd_q   <= {rd_q[`EXEC_MUL_STAGES-2:0], issue.rd};
    // stage one, extended operands
    op1_q  <= issue.op.mul.func;
    a_q    <= {a_signed & issue.a[`EXEC_XLEN-1], issue.a};
    b_q    <= {b_signed & issue.b[`EXEC_XLEN-1], issue.b};
    // stage two, full product
    op2_q  <= op1_q;
    prod_q <= prod_full[2*`EXEC_XLEN-1:0];
    // stage three, half select
    data_q <= (op2_q == exec_pkg::MUL_LO) ? prod_q[`EXEC_XLEN-1:0]
                                          : prod_q[2*`EXEC_XLEN-1:`EXEC_XLEN];
  end

  assign mul_res.wb.valid = vld[`EXEC_MUL_STAGES-1];
  assign mul_res.wb.tag   = tag_q[`EXEC_MUL_STAGES-1];
  assign mul_res.wb.rd    = rd_q[`EXEC_MUL_STAGES-1];
  assign mul_res.wb.wen   = vld[`EXEC_MUL_STAGES-1];
  assign mul_res.wb.data  = data_q;
  // stage two moves to the output next edge
  assign mul_res.busy_next = vld[1];

endmodule

/* sim.f */
+incdir+design
design/exec_pkg.sv
design/exec_alu.sv
design/branch_resolve.sv
design/mul_pipe.sv
design/exec_ctrl.sv
design/exec_stage.sv
tests/exec_stage_chk.sv
tests/exec_stage_tb.sv

/* tests/exec_stage_chk.sv */
`timescale 1ns/1ps

module exec_stage_chk (
  input logic                CLK,
  input logic                nRST,
  input exec_pkg::issue_t    issue,
  input logic                issue_ready,
  input logic                commit_stall,
  input exec_pkg::wb_t       wb,
  input exec_pkg::redirect_t redirect
);

  logic branch_accept;

  // branch or jump taken by the stage this cycle
  assign branch_accept = issue.valid & issue_ready &
                         (issue.unit == exec_pkg::UNIT_BRANCH);

  // stall always holds off issue
  stall_blocks_issue: assert property (
    @(posedge CLK) disable iff (!nRST) commit_stall |-> !issue_ready
  ) else $error("issue_ready high while commit_stall is high");

  // no write without a completion
  wen_needs_valid: assert property (
    @(posedge CLK) disable iff (!nRST) wb.wen |-> wb.valid
  ) else $error("wb.wen high while wb.valid is low");

  // redirect is one cycle behind its branch
  redirect_from_branch: assert property (
    @(posedge CLK) disable iff (!nRST) redirect.valid |-> $past(branch_accept)
  ) else $error("redirect.valid without a branch issued the cycle before");

endmodule

/* tests/exec_stage_tb.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_stage_tb;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int N_ALU      = 200;
  localparam int N_MUL      = 48;
  localparam int N_BR       = 100;
  localparam int N_JMP      = 30;
  // refusal pairs plus stall and flush ops
  localparam int N_CTRL     = 24;
  localparam int N_OPS      = N_ALU + N_MUL + N_BR + N_JMP + N_CTRL;
  localparam int WATCHDOG_NS = (N_OPS * 5 + RST_CYCLES) * CLK_PERIOD;

  logic                  CLK;
  logic                  nRST;
  exec_pkg::issue_t      issue;
  logic                  issue_ready;
  logic                  flush;
  logic                  commit_stall;
  exec_pkg::wb_t         wb;
  exec_pkg::commit_t     commit;
  exec_pkg::redirect_t   redirect;

  int                     cyc = 0;
  int                     errors = 0;
  logic [31:0]            rng_state = 32'h5941_c5e0;
  logic [`EXEC_TAG_W-1:0] tag_ctr = '0;

  // expectations keyed by the cycle they are due in
  exec_pkg::wb_t       exp_wb[int];
  exec_pkg::commit_t   exp_commit[int];
  exec_pkg::redirect_t exp_redir[int];
  // cycles in which a multiply was accepted
  bit                  mul_sent[int];
  // model of the registered commit record
  exec_pkg::commit_t   commit_model = '0;

  exec_stage DUT (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue        (issue),
    .issue_ready  (issue_ready),
    .flush        (flush),
    .commit_stall (commit_stall),
    .wb           (wb),
    .commit       (commit),
    .redirect     (redirect)
  );

  bind exec_stage exec_stage_chk u_chk (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue        (issue),
    .issue_ready  (issue_ready),
    .commit_stall (commit_stall),
    .wb           (wb),
    .redirect     (redirect)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // counts every rising edge
  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check_eq(input string what, input logic [127:0] got,
                          input logic [127:0] want);
    if (got !== want) begin
      errors = errors + 1;
      $display("** Error @ %0d ns: %s is %0h, expected %0h", $time, what, got, want);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // xorshift32 step on the shared state
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] alu_expect(input exec_pkg::alu_op_e f,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (f)
      exec_pkg::ALU_ADD:  return a + b;
      // two's complement subtract
      exec_pkg::ALU_SUB:  return a + ~b + 32'd1;
      exec_pkg::ALU_AND:  return a & b;
      exec_pkg::ALU_OR:   return a | b;
      exec_pkg::ALU_XOR:  return a ^ b;
      exec_pkg::ALU_SLL:  return a << b[4:0];
      exec_pkg::ALU_SRL:  return a >> b[4:0];
      exec_pkg::ALU_SRA:  return ext[31:0];
      // negative operand is less when signs differ
      exec_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      exec_pkg::ALU_SLTU: return {31'd0, a < b};
      default:            return 32'd0;
    endcase
  endfunction

  function automatic logic branch_cond(input exec_pkg::br_cond_e c,
                                       input logic [31:0] a, input logic [31:0] b);
    logic lt_s;
    // flip sign bits to order signed values as unsigned
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (c)
      exec_pkg::BR_EQ:  return a == b;
      exec_pkg::BR_NE:  return a != b;
      exec_pkg::BR_LT:  return lt_s;
      exec_pkg::BR_GE:  return !lt_s;
      exec_pkg::BR_LTU: return a < b;
      exec_pkg::BR_GEU: return !(a < b);
      default:          return 1'b0;
    endcase
  endfunction

  // expected wb, commit and redirect for one accepted op
  function automatic void ref_model(input exec_pkg::issue_t op, output exec_pkg::wb_t w,
                                    output exec_pkg::commit_t c,
                                    output exec_pkg::redirect_t r);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        prod;
    logic [31:0]        link;
    logic               taken;
    w = '0;
    c = '0;
    r = '0;
    w.valid = 1'b1;
    w.tag   = op.tag;
    w.rd    = op.rd;
    link    = op.pc + 32'(`EXEC_INSN_BYTES);
    c.valid = 1'b1;
    c.pc    = op.pc;
    c.pc4   = link;
    c.prediction    = op.prediction;
    c.resolved_addr = link;
    if (op.unit == exec_pkg::UNIT_MUL) begin
      sa = {{32{op.a[31]}}, op.a};
      sb = {{32{op.b[31]}}, op.b};
      // unsigned operands drop the sign extension
      if (op.op.mul.func == exec_pkg::MUL_HU) begin
        sa[63:32] = '0;
      end
      if (op.op.mul.func != exec_pkg::MUL_H) begin
        sb[63:32] = '0;
      end
      prod   = sa * sb;
      w.wen  = 1'b1;
      w.data = (op.op.mul.func == exec_pkg::MUL_LO) ? prod[31:0] : prod[63:32];
      c = '0;
    end else if (op.unit == exec_pkg::UNIT_BRANCH) begin
      taken  = op.op.br.jump | branch_cond(op.op.br.cond, op.a, op.b);
      w.wen  = op.op.br.jump;
      w.data = link;
      c.branch_instr  = ~op.op.br.jump;
      c.taken         = taken;
      c.resolved_addr = taken ? op.pc + op.imm : link;
      r.valid = op.op.br.jump | (taken != op.prediction);
      r.addr  = c.resolved_addr;
    end else begin
      w.wen  = 1'b1;
      w.data = alu_expect(op.op.alu, op.a, op.b);
    end
  endfunction

  function automatic exec_pkg::issue_t make_op(input exec_pkg::unit_e unit, input logic jump);
    exec_pkg::issue_t op;
    logic [31:0]      r;
    op = '0;
    r  = xorshift32();
    op.valid      = 1'b1;
    op.unit       = unit;
    op.tag        = tag_ctr;
    tag_ctr       = tag_ctr + 1'b1;
    op.rd         = r[4:0];
    op.prediction = r[5];
    op.pc         = xorshift32() & 32'hffff_fffc;
    op.a          = xorshift32();
    // equal operands now and then for eq and ge
    op.b          = r[6] ? op.a : xorshift32();
    op.imm        = xorshift32();
    case (unit)
      exec_pkg::UNIT_ALU: begin
        op.op.alu = exec_pkg::alu_op_e'(4'(r[31:8] % 24'd10));
      end
      exec_pkg::UNIT_BRANCH: begin
        op.op.br.cond = exec_pkg::br_cond_e'(3'(r[31:8] % 24'd6));
        op.op.br.jump = jump;
      end
      default: begin
        op.op.mul.func = exec_pkg::mul_op_e'(r[9:8]);
      end
    endcase
    return op;
  endfunction

  // drive one cycle and record what is due afterwards
  task automatic drive_cycle(input exec_pkg::issue_t op, input logic stall, input logic fl,
                             output logic accepted);
    exec_pkg::wb_t       w;
    exec_pkg::commit_t   c;
    exec_pkg::redirect_t r;
    logic                is_mul;
    logic                exp_ready;
    @(posedge CLK);
    #2;
    issue        = op;
    commit_stall = stall;
    flush        = fl;
    is_mul       = op.unit == exec_pkg::UNIT_MUL;
    // a multiply two cycles back owns the next wb slot
    exp_ready    = !stall && !fl && !(mul_sent.exists(cyc - 2) && !is_mul);
    #1;
    check_eq("issue_ready", 128'(issue_ready), 128'(exp_ready));
    accepted = op.valid && exp_ready;
    ref_model(op, w, c, r);
    if (accepted && is_mul) begin
      mul_sent[cyc]   = 1'b1;
      exp_wb[cyc + 3] = w;
    end else if (accepted) begin
      exp_wb[cyc + 1] = w;
    end
    if (fl) begin
      commit_model = '0;
    end else if (!stall) begin
      commit_model = (accepted && !is_mul) ? c : '0;
    end
    exp_commit[cyc + 1] = commit_model;
    exp_redir[cyc + 1]  = (!fl && accepted && !is_mul) ? r : '0;
  endtask

  // offer until the DUT takes it
  task automatic send_op(input exec_pkg::issue_t op);
    logic acc;
    acc = 1'b0;
    while (!acc) begin
      drive_cycle(op, 1'b0, 1'b0, acc);
    end
  endtask

  always @(negedge CLK) begin : compare_outputs
    exec_pkg::wb_t       ew;
    exec_pkg::commit_t   ec;
    exec_pkg::redirect_t er;
    if (exp_commit.exists(cyc)) begin
      ec = exp_commit[cyc];
      er = exp_redir[cyc];
      if (exp_wb.exists(cyc)) begin
        ew = exp_wb[cyc];
        if (ew.wen) begin
          check_eq("wb", 128'(wb), 128'(ew));
        end else begin
          // branch retires its tag without data
          check_eq("wb without write", 128'({wb.valid, wb.tag, wb.rd, wb.wen}),
                   128'({ew.valid, ew.tag, ew.rd, ew.wen}));
        end
        exp_wb.delete(cyc);
      end else begin
        check_eq("wb.valid when idle", 128'(wb.valid), 128'(1'b0));
      end
      if (ec.valid) begin
        check_eq("commit", 128'(commit), 128'(ec));
      end else begin
        check_eq("commit.valid", 128'(commit.valid), 128'(1'b0));
      end
      if (er.valid) begin
        check_eq("redirect", 128'(redirect), 128'(er));
      end else begin
        check_eq("redirect.valid", 128'(redirect.valid), 128'(1'b0));
      end
      exp_commit.delete(cyc);
      exp_redir.delete(cyc);
    end
  end

  initial begin : main
    exec_pkg::issue_t op;
    exec_pkg::issue_t nop;
    logic             acc;
    nop          = '0;
    issue        = '0;
    flush        = 1'b0;
    commit_stall = 1'b0;
    nRST         = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    #2;
    nRST = 1'b1;
    @(negedge CLK);
    // idle state out of reset
    check_eq("wb.valid after reset", 128'(wb.valid), 128'(1'b0));
    check_eq("commit.valid after reset", 128'(commit.valid), 128'(1'b0));
    check_eq("redirect.valid after reset", 128'(redirect.valid), 128'(1'b0));
    check_eq("issue_ready after reset", 128'(issue_ready), 128'(1'b1));

    repeat (N_ALU) send_op(make_op(exec_pkg::UNIT_ALU, 1'b0));
    // multiplies back to back
    repeat (N_MUL) send_op(make_op(exec_pkg::UNIT_MUL, 1'b0));
    // alu offered two cycles behind a multiply is held off
    repeat (4) begin
      drive_cycle(make_op(exec_pkg::UNIT_MUL, 1'b0), 1'b0, 1'b0, acc);
      check_eq("issue_ready for mul", 128'(issue_ready), 128'(1'b1));
      drive_cycle(nop, 1'b0, 1'b0, acc);
      op = make_op(exec_pkg::UNIT_ALU, 1'b0);
      drive_cycle(op, 1'b0, 1'b0, acc);
      check_eq("issue_ready for alu behind mul", 128'(issue_ready), 128'(1'b0));
      send_op(op);
    end
    repeat (N_BR) send_op(make_op(exec_pkg::UNIT_BRANCH, 1'b0));
    repeat (N_JMP) send_op(make_op(exec_pkg::UNIT_BRANCH, 1'b1));

    // record holds and offers are refused while stalled
    send_op(make_op(exec_pkg::UNIT_ALU, 1'b0));
    repeat (3) begin
      drive_cycle(make_op(exec_pkg::UNIT_BRANCH, 1'b0), 1'b1, 1'b0, acc);
      check_eq("issue_ready under stall", 128'(issue_ready), 128'(1'b0));
    end
    // jump held by stall and then flushed
    send_op(make_op(exec_pkg::UNIT_BRANCH, 1'b1));
    drive_cycle(nop, 1'b1, 1'b0, acc);
    drive_cycle(make_op(exec_pkg::UNIT_ALU, 1'b0), 1'b1, 1'b1, acc);
    check_eq("issue_ready under flush", 128'(issue_ready), 128'(1'b0));
    // multiply in flight survives a flush
    send_op(make_op(exec_pkg::UNIT_MUL, 1'b0));
    drive_cycle(nop, 1'b0, 1'b1, acc);
    repeat (4) drive_cycle(nop, 1'b0, 1'b0, acc);
    repeat (2) @(posedge CLK);

    check_eq("results still pending", 128'(exp_wb.num()), 128'(0));
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
